/* usb_link_pkg.sv */
package usb_link_pkg;

    // ==================================================
    // request types seen by the arbiter and former
    // ==================================================
    typedef enum logic [3:0] {
        pkt_ack    = 4'd1,
        pkt_nak    = 4'd2,
        pkt_stl    = 4'd3,
        pkt_didx   = 4'd5,  // device index command.
        pkt_dparam = 4'd6,  // sampling parameter command.
        pkt_ddidx  = 4'd7   // data index command.
    } pkt_type_e;

    // ==================================================
    // PID byte values on the wire
    // ==================================================
    typedef enum logic [7:0] {
        pid_sync = 8'h01,  // also serves as the SYNC byte.
        pid_ack  = 8'h2D,
        pid_nak  = 8'hA5,
        pid_stl  = 8'hE1,
        pid_cmd  = 8'h1E
    } pid_e;

    // ==================================================
    // command payload headers
    // ==================================================
    // the header sits in the upper nibble of the first payload byte.
    localparam logic [3:0] head_ddidx  = 4'h1;
    localparam logic [3:0] head_dparam = 4'h5;
    localparam logic [3:0] head_didx   = 4'h9;

    // ==================================================
    // CRC5 constants
    // ==================================================
    // x^5 + x^2 + 1 without the implicit top term.
    localparam logic [4:0] crc5_poly = 5'b00101;
    localparam logic [4:0] crc5_init = 5'b11111;

endpackage

/* usb_tx_ctrl_pkg.sv */
package usb_tx_ctrl_pkg;

    // ==================================================
    // packet former states
    // ==================================================
    typedef enum logic [2:0] {
        idle,   // waiting for a request.
        sync,   // SYNC byte on txd.
        wpid,   // PID byte on txd.
        dnum0,  // zero byte of a command.
        dnum1,  // length byte of a command.
        wcmd,   // payload bytes.
        crc     // CRC5 byte.
    } tx_state_e;

    // ==================================================
    // arbiter sources
    // ==================================================
    typedef enum logic {
        src_hs  = 1'b0,  // handshake requester.
        src_cmd = 1'b1   // command requester.
    } src_e;

endpackage

/* crc5.sv */
module crc5 (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       en,
    input  logic [7:0] din,
    output logic [7:0] crc
);
    import usb_link_pkg::*;

    logic [4:0] crc_q;

    // folds one byte into the register, least significant bit first.
    function automatic logic [4:0] fold_byte(input logic [4:0] cur, input logic [7:0] data);
        logic [4:0] acc;
        logic       fb;
        acc = cur;
        for (int i = 0; i < 8; i++) begin
            fb  = acc[4] ^ data[i];
            acc = {acc[3:0], 1'b0};
            if (fb) begin
                acc = acc ^ crc5_poly;
            end
        end
        return acc;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= crc5_init;
        end else if (clear) begin
            crc_q <= crc5_init;  // a new packet always restarts the check.
        end else if (en) begin
            crc_q <= fold_byte(crc_q, din);
        end
    end

    assign crc = {3'b000, ~crc_q};  // the wire carries the complement.

endmodule

/* tx_arbiter.sv */
module tx_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hs_valid,
    input  usb_link_pkg::pkt_type_e hs_type,
    output logic                    hs_ready,
    input  logic                    cmd_valid,
    input  usb_link_pkg::pkt_type_e cmd_type,
    input  logic [31:0]             cmd_word,
    output logic                    cmd_ready,
    output logic                    pkt_valid,
    output usb_link_pkg::pkt_type_e pkt_type,
    output logic [31:0]             pkt_word,
    input  logic                    pkt_ready
);
    import usb_tx_ctrl_pkg::*;

    src_e prio_q;  // source favoured when both request.
    src_e sel;

    always_comb begin
        if (hs_valid && cmd_valid) begin
            sel = prio_q;
        end else if (hs_valid) begin
            sel = src_hs;
        end else if (cmd_valid) begin
            sel = src_cmd;
        end else begin
            sel = prio_q;
        end
    end

    assign pkt_valid = hs_valid || cmd_valid;
    assign pkt_type  = (sel == src_hs) ? hs_type : cmd_type;
    assign pkt_word  = (sel == src_hs) ? 32'd0 : cmd_word;  // handshakes carry no data.
    assign hs_ready  = pkt_ready && (sel == src_hs);
    assign cmd_ready = pkt_ready && (sel == src_cmd);

    // after each transfer the other source gets the next turn.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prio_q <= src_hs;
        end else if (pkt_valid && pkt_ready) begin
            prio_q <= (sel == src_hs) ? src_cmd : src_hs;
        end
    end

    // ==================================================
    // checks
    // ==================================================
    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        !(hs_ready && cmd_ready));

endmodule

/* usb_tx.sv */
module usb_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pkt_valid,
    input  usb_link_pkg::pkt_type_e pkt_type,
    input  logic [31:0]             pkt_word,
    output logic                    pkt_ready,
    output logic                    crc_clear,
    output logic                    crc_en,
    output logic [7:0]              crc_din,
    input  logic [7:0]              crc_out,
    output logic [7:0]              txd,
    output logic                    txd_valid,
    input  logic                    txd_ready
);
    import usb_link_pkg::*;
    import usb_tx_ctrl_pkg::*;

    tx_state_e   state;
    tx_state_e   state_d;
    pkt_type_e   type_q;
    logic [19:0] word_q;   // command fields from word bits 31..12.
    logic [1:0]  len_q;
    logic [1:0]  pay_cnt;
    logic        accept;
    logic        take;
    logic        is_hs;
    logic        last_pay;
    logic [7:0]  pid_byte;
    logic [7:0]  pay_byte;

    assign accept   = pkt_valid && pkt_ready;
    assign take     = txd_valid && txd_ready;
    assign is_hs    = type_q inside {pkt_ack, pkt_nak, pkt_stl};
    assign last_pay = (pay_cnt + 2'd1) == len_q;

    // ==================================================
    // request capture and payload counter
    // ==================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            type_q <= pkt_type;
            word_q <= pkt_word[31:12];
            len_q  <= (pkt_type == pkt_dparam) ? 2'd2 : 2'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= idle;
            pay_cnt <= 2'd0;
        end else begin
            state <= state_d;
            if (accept) begin
                pay_cnt <= 2'd0;
            end else if (state == wcmd && take) begin
                pay_cnt <= pay_cnt + 2'd1;
            end
        end
    end

    // every state but idle holds one byte until the sink takes it.
    always_comb begin
        state_d = state;
        case (state)
            idle:    if (accept) state_d = sync;
            sync:    if (take) state_d = wpid;
            wpid:    if (take) state_d = is_hs ? idle : dnum0;
            dnum0:   if (take) state_d = dnum1;
            dnum1:   if (take) state_d = wcmd;
            wcmd:    if (take && last_pay) state_d = crc;
            crc:     if (take) state_d = idle;
            default: state_d = idle;
        endcase
    end

    // ==================================================
    // byte selection
    // ==================================================
    always_comb begin
        case (type_q)
            pkt_ack: pid_byte = pid_ack;
            pkt_nak: pid_byte = pid_nak;
            pkt_stl: pid_byte = pid_stl;
            default: pid_byte = pid_cmd;
        endcase
    end

    always_comb begin
        case (type_q)
            pkt_didx:   pay_byte = {head_didx, word_q[19:16]};
            pkt_ddidx:  pay_byte = {head_ddidx, word_q[15:12]};
            pkt_dparam: pay_byte = (pay_cnt == 2'd0) ? {head_dparam, word_q[11:8]}
                                                     : word_q[7:0];  // upper over lower filter.
            default:    pay_byte = 8'h00;
        endcase
    end

    always_comb begin
        case (state)
            sync:    txd = pid_sync;
            wpid:    txd = pid_byte;
            dnum1:   txd = {6'd0, len_q};
            wcmd:    txd = pay_byte;
            crc:     txd = crc_out;
            default: txd = 8'h00;  // idle and the zero byte.
        endcase
    end

    assign txd_valid = (state != idle);
    assign pkt_ready = (state == idle);
    assign crc_clear = accept;
    assign crc_en    = take && (state == dnum1 || state == wcmd);  // length and payload only.
    assign crc_din   = txd;

    // ==================================================
    // checks
    // ==================================================
    a_txd_hold: assert property (@(posedge clk) disable iff (rst)
        txd_valid && !txd_ready |=> txd_valid && $stable(txd));

    // requests are taken only between packets.
    a_ready_idle: assert property (@(posedge clk) disable iff (rst)
        pkt_ready |-> state == idle);

    a_no_crc_head: assert property (@(posedge clk) disable iff (rst)
        state inside {sync, wpid} |-> !crc_en);

endmodule

/* usb_tx_top.sv */
module usb_tx_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hs_valid,
    input  usb_link_pkg::pkt_type_e hs_type,
    output logic                    hs_ready,
    input  logic                    cmd_valid,
    input  usb_link_pkg::pkt_type_e cmd_type,
    input  logic [31:0]             cmd_word,
    output logic                    cmd_ready,
    output logic [7:0]              txd,
    output logic                    txd_valid,
    input  logic                    txd_ready
);
    import usb_link_pkg::*;

    logic        pkt_valid;
    pkt_type_e   pkt_type;
    logic [31:0] pkt_word;
    logic        pkt_ready;
    logic        crc_clear;
    logic        crc_en;
    logic [7:0]  crc_din;
    logic [7:0]  crc_out;

    tx_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .hs_valid  (hs_valid),
        .hs_type   (hs_type),
        .hs_ready  (hs_ready),
        .cmd_valid (cmd_valid),
        .cmd_type  (cmd_type),
        .cmd_word  (cmd_word),
        .cmd_ready (cmd_ready),
        .pkt_valid (pkt_valid),
        .pkt_type  (pkt_type),
        .pkt_word  (pkt_word),
        .pkt_ready (pkt_ready)
    );

    usb_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .pkt_valid (pkt_valid),
        .pkt_type  (pkt_type),
        .pkt_word  (pkt_word),
        .pkt_ready (pkt_ready),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc_din   (crc_din),
        .crc_out   (crc_out),
        .txd       (txd),
        .txd_valid (txd_valid),
        .txd_ready (txd_ready)
    );

    crc5 u_crc5 (
        .clk   (clk),
        .rst   (rst),
        .clear (crc_clear),
        .en    (crc_en),
        .din   (crc_din),
        .crc   (crc_out)
    );

endmodule

/* tb_usb_tx.sv */
module tb_usb_tx;
    timeunit 1ns;
    timeprecision 1ps;
    import usb_link_pkg::*;
    import usb_tx_ctrl_pkg::*;

    localparam int n_tests = 11;

    logic        clk;
    logic        rst;
    logic        hs_valid;
    pkt_type_e   hs_type;
    logic        hs_ready;
    logic        cmd_valid;
    pkt_type_e   cmd_type;
    logic [31:0] cmd_word;
    logic        cmd_ready;
    logic [7:0]  txd;
    logic        txd_valid;
    logic        txd_ready;

    string       t_name [n_tests];
    logic        t_hs [n_tests];
    pkt_type_e   t_hs_type [n_tests];
    logic        t_cmd [n_tests];
    pkt_type_e   t_cmd_type [n_tests];
    logic [31:0] t_word [n_tests];
    logic        t_bp [n_tests];
    int          n_loaded = 0;

    logic [7:0]  exp_q[$];
    bit          kind_q[$];  // set for the PID byte.
    string       cur_name;
    bit          bp_on;
    bit          hs_pend;
    bit          cmd_pend;
    src_e        prio_m = src_hs;
    logic [31:0] lfsr_q = 32'h1f7bde2a;

    usb_tx_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(n_tests * 40 * 10);
        fail_stop($sformatf("timeout: the run did not finish within %0d cycles", n_tests * 40));
    end

    // ==================================================
    // reporting and compare tasks
    // ==================================================
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch test=%s expected=%h actual=%h", name, exp, act));
        end
    endtask

    task automatic check_pid(input string name, input pid_e exp, input pid_e act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch test=%s pid expected=%h actual=%h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch test=%s expected=%b actual=%b", name, exp, act));
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // taps of x^32+x^22+x^2+x+1.
        return {s[30:0], fb};
    endfunction

    function automatic logic [4:0] crc5_ref(input logic [4:0] r, input logic [7:0] b);
        logic [4:0] x;
        x = r;
        for (int i = 0; i < 8; i++) begin
            if (x[4] ^ b[i]) begin
                x = {x[3:0], 1'b0} ^ crc5_poly;
            end else begin
                x = {x[3:0], 1'b0};
            end
        end
        return x;
    endfunction

    task automatic push_exp(input logic [7:0] b, input bit is_pid);
        exp_q.push_back(b);
        kind_q.push_back(is_pid);
    endtask

    task automatic queue_packet(input pkt_type_e t, input logic [31:0] w);
        logic [7:0] pay[$];
        logic [4:0] r;
        push_exp(pid_sync, 1'b0);
        if (t == pkt_ack || t == pkt_nak || t == pkt_stl) begin
            push_exp((t == pkt_ack) ? pid_ack : (t == pkt_nak) ? pid_nak : pid_stl, 1'b1);
        end else begin
            push_exp(pid_cmd, 1'b1);
            push_exp(8'h00, 1'b0);
            if (t == pkt_didx) begin
                pay.push_back({head_didx, w[31:28]});
            end else if (t == pkt_ddidx) begin
                pay.push_back({head_ddidx, w[27:24]});
            end else begin
                pay.push_back({head_dparam, w[23:20]});
                pay.push_back(w[19:12]);  // upper filter over lower filter.
            end
            push_exp(8'(pay.size()), 1'b0);
            r = crc5_ref(crc5_init, 8'(pay.size()));
            foreach (pay[k]) begin
                push_exp(pay[k], 1'b0);
                r = crc5_ref(r, pay[k]);
            end
            push_exp({3'b000, ~r}, 1'b0);
        end
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    task automatic add_entry(input string name, input logic hs, input pkt_type_e ht,
                             input logic cm, input pkt_type_e ct, input logic [31:0] w,
                             input logic bp);
        t_name[n_loaded]     = name;
        t_hs[n_loaded]       = hs;
        t_hs_type[n_loaded]  = ht;
        t_cmd[n_loaded]      = cm;
        t_cmd_type[n_loaded] = ct;
        t_word[n_loaded]     = w;
        t_bp[n_loaded]       = bp;
        n_loaded++;
    endtask

    // handles one clock edge by collecting a byte, following arbitration and driving txd_ready.
    task automatic step_cycle();
        logic [7:0] e;
        bit         is_pid;
        if (txd_valid && txd_ready) begin
            if (exp_q.size() == 0) begin
                fail_stop($sformatf("test %s: byte %h sent with no packet pending",
                                    cur_name, txd));
            end
            e      = exp_q.pop_front();
            is_pid = kind_q.pop_front();
            if (is_pid) begin
                check_pid(cur_name, pid_e'(e), pid_e'(txd));
            end else begin
                check_byte(cur_name, e, txd);
            end
        end
        if (hs_valid && cmd_valid) begin
            if (prio_m == src_hs) begin
                check_flag({cur_name, " cmd_ready"}, 1'b0, cmd_ready);
            end else begin
                check_flag({cur_name, " hs_ready"}, 1'b0, hs_ready);
            end
        end
        if (hs_valid && hs_ready) begin
            queue_packet(hs_type, 32'd0);
            prio_m   = src_cmd;
            hs_pend  = 1'b0;
            hs_valid <= 1'b0;
        end
        if (cmd_valid && cmd_ready) begin
            queue_packet(cmd_type, cmd_word);
            prio_m    = src_hs;
            cmd_pend  = 1'b0;
            cmd_valid <= 1'b0;
        end
        if (bp_on) begin
            lfsr_q = lfsr_next(lfsr_q);
            txd_ready <= lfsr_q[0];
        end else begin
            txd_ready <= 1'b1;
        end
    endtask

    task automatic run_entry(input int i);
        cur_name = t_name[i];
        bp_on    = t_bp[i];
        hs_pend  = t_hs[i];
        cmd_pend = t_cmd[i];
        @(posedge clk);
        step_cycle();
        hs_valid  <= t_hs[i];
        hs_type   <= t_hs_type[i];
        cmd_valid <= t_cmd[i];
        cmd_type  <= t_cmd_type[i];
        cmd_word  <= t_word[i];
        while (hs_pend || cmd_pend || exp_q.size() != 0 || txd_valid) begin
            @(posedge clk);
            step_cycle();
        end
        bp_on = 1'b0;
        repeat (2) begin
            @(posedge clk);
            step_cycle();  // an idle link must stay silent.
        end
    endtask

    initial begin
        rst       = 1'b1;
        hs_valid  = 1'b0;
        hs_type   = pkt_ack;
        cmd_valid = 1'b0;
        cmd_type  = pkt_didx;
        cmd_word  = 32'd0;
        txd_ready = 1'b1;
        add_entry("pair_ack_didx",    1, pkt_ack, 1, pkt_didx,   32'hA3000000, 0);
        add_entry("single_nak",       1, pkt_nak, 0, pkt_didx,   32'h00000000, 0);
        add_entry("single_stall",     1, pkt_stl, 0, pkt_didx,   32'h00000000, 0);
        add_entry("pair_stall_ddidx", 1, pkt_stl, 1, pkt_ddidx,  32'h0C000000, 0);
        add_entry("cmd_didx",         0, pkt_ack, 1, pkt_didx,   32'h7F000000, 0);
        add_entry("cmd_ddidx",        0, pkt_ack, 1, pkt_ddidx,  32'h15000000, 0);
        add_entry("cmd_dparam",       0, pkt_ack, 1, pkt_dparam, 32'h00B4D000, 0);
        add_entry("bp_dparam",        0, pkt_ack, 1, pkt_dparam, 32'hFF3A6FFF, 1);
        add_entry("bp_ack",           1, pkt_ack, 0, pkt_didx,   32'h00000000, 1);
        add_entry("bp_pair_nak_didx", 1, pkt_nak, 1, pkt_didx,   32'h5E000000, 1);
        add_entry("bp_ddidx",         0, pkt_ack, 1, pkt_ddidx,  32'h09000000, 1);
        repeat (10) begin
            @(posedge clk);
            check_flag("reset", 1'b0, txd_valid);
        end
        rst <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            check_flag("after_reset", 1'b0, txd_valid);
            check_byte("after_reset", 8'h00, txd);
            check_flag("after_reset hs_ready", 1'b1, hs_ready);  // pointer starts at handshake.
        end
        for (int i = 0; i < n_loaded; i++) begin
            run_entry(i);
        end
        @(posedge clk);
        if (exp_q.size() != 0 || txd_valid) begin
            fail_stop("bytes were still pending when the table was done");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* filelist.f */
usb_link_pkg.sv
usb_tx_ctrl_pkg.sv
crc5.sv
tx_arbiter.sv
usb_tx.sv
usb_tx_top.sv
tb_usb_tx.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_usb_tx
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
